// ==== hw/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// load/store buffer size, as a power of two
`define LSB_DEPTH_BITS 3
`define LSB_DEPTH (1 << `LSB_DEPTH_BITS)

// reorder buffer tag width
// tag zero is reserved for "value already present"
`define ROB_TAG_BITS 5

// result broadcast ports watched by waiting entries
`define CDB_PORTS 2

// data memory in words
`define MEM_ADDR_BITS 8

// cycles from timer start to timer done
`define MEM_LATENCY 3

`endif

// ==== hw/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [31:0]                  word_t;
    typedef logic [`ROB_TAG_BITS-1:0]     rob_tag_t;
    typedef logic [4:0]                   reg_idx_t;
    typedef logic [`LSB_DEPTH_BITS-1:0]   lsb_idx_t;
    typedef logic [`MEM_ADDR_BITS-1:0]    mem_addr_t;

    typedef enum logic {
        op_lw,
        op_sw
    } lsu_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_done
    } mem_state_t;

    // one instruction from rename
    typedef struct packed {
        lsu_op_t  op;
        rob_tag_t tag;
        reg_idx_t rd;
        rob_tag_t base_tag;
        word_t    base_val;
        rob_tag_t data_tag;
        word_t    data_val;
        word_t    imm;
    } ls_issue_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    // access handed to the memory controller
    typedef struct packed {
        lsu_op_t  op;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    addr;
        word_t    data;
    } ls_entry_t;

    // data is zero for a store
    typedef struct packed {
        lsu_op_t  op;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    data;
    } lsu_result_t;

endpackage

// ==== hw/ls_buffer.sv ====
`timescale 1ns/100ps
`include "lsu_defines.svh"

module ls_buffer
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      issue_valid,
    input  ls_issue_t issue,
    input  cdb_t      cdb [`CDB_PORTS],
    input  rob_tag_t  rob_head,
    input  logic      accept,
    output logic      full,
    output logic      disp_valid,
    output ls_entry_t disp
);

    // payload per slot
    // addr and data in slot are kept current as operands arrive
    ls_entry_t slot     [`LSB_DEPTH];
    rob_tag_t  base_tag [`LSB_DEPTH];
    rob_tag_t  data_tag [`LSB_DEPTH];
    word_t     imm      [`LSB_DEPTH];

    logic [`LSB_DEPTH-1:0] busy;

    // head is the oldest entry, tail the next free slot
    lsb_idx_t head;
    lsb_idx_t tail;

    logic do_issue;
    logic head_ready;
    logic store_blocked;

    // tail only catches up with a busy head when every slot is taken
    assign full     = busy[tail];
    assign do_issue = issue_valid && !full;

    assign head_ready = busy[head]
                        && base_tag[head] == '0
                        && data_tag[head] == '0;

    // a store must be the oldest instruction in the ROB
    assign store_blocked = slot[head].op == op_sw && slot[head].tag != rob_head;

    assign disp_valid = accept && head_ready && !store_blocked;
    assign disp       = slot[head];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (do_issue) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (disp_valid) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // CDB wakeup of every waiting entry
        for (int i = 0; i < `LSB_DEPTH; i++) begin
            if (busy[i]) begin
                // scan ports downward so port 0 is written last and wins
                for (int p = `CDB_PORTS - 1; p >= 0; p--) begin
                    if (cdb[p].valid && base_tag[i] != '0 && cdb[p].tag == base_tag[i]) begin
                        base_tag[i]  <= '0;
                        slot[i].addr <= cdb[p].value + imm[i];
                    end
                    if (cdb[p].valid && data_tag[i] != '0 && cdb[p].tag == data_tag[i]) begin
                        data_tag[i]  <= '0;
                        slot[i].data <= cdb[p].value;
                    end
                end
            end
        end

        // new entry at the tail
        // the address is valid only once base_tag is zero
        if (do_issue) begin
            slot[tail].op   <= issue.op;
            slot[tail].tag  <= issue.tag;
            slot[tail].rd   <= issue.rd;
            slot[tail].addr <= issue.base_val + issue.imm;
            slot[tail].data <= issue.data_val;
            base_tag[tail]  <= issue.base_tag;
            data_tag[tail]  <= issue.data_tag;
            imm[tail]       <= issue.imm;
        end
    end

    // rename must hold off while full is high
    a_no_issue_when_full: assert property (
        @(posedge clk) disable iff (reset || flush)
        issue_valid |-> !full
    ) else $error("ls_buffer: issue while full");

endmodule

// ==== hw/mem_ctrl_fsm.sv ====
`timescale 1ns/100ps
`include "lsu_defines.svh"

module mem_ctrl_fsm
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        disp_valid,
    input  ls_entry_t   disp,
    input  logic        timer_done,
    input  word_t       mem_rdata,
    output logic        accept,
    output logic        timer_start,
    output logic        mem_en,
    output logic        mem_we,
    output mem_addr_t   mem_addr,
    output word_t       mem_wdata,
    output logic        result_valid,
    output lsu_result_t result
);

    mem_state_t state;
    ls_entry_t  entry;
    logic       launch;

    assign accept = state == st_idle;
    assign launch = disp_valid && accept;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state       <= st_idle;
            timer_start <= 1'b0;
            mem_en      <= 1'b0;
        end else begin
            // memory and timer both fire in the first access cycle
            timer_start <= launch;
            mem_en      <= launch;
            case (state)
                st_idle:   if (launch) state <= st_access;
                st_access: if (timer_done) state <= st_done;
                st_done:   state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            entry <= disp;
        end
    end

    // word index, byte offset dropped
    assign mem_addr  = entry.addr[`MEM_ADDR_BITS+1:2];
    assign mem_we    = entry.op == op_sw;
    assign mem_wdata = (entry.op == op_sw) ? entry.data : '0;

    // read data stays on rdata until the next access
    assign result_valid = state == st_done;
    assign result.op    = entry.op;
    assign result.tag   = entry.tag;
    assign result.rd    = entry.rd;
    assign result.data  = (entry.op == op_lw) ? mem_rdata : '0;

    // buffer only dispatches on accept
    a_disp_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        disp_valid |-> state == st_idle
    ) else $error("mem_ctrl_fsm: dispatch while busy");

endmodule

// ==== hw/mem_latency_timer.sv ====
`timescale 1ns/100ps
`include "lsu_defines.svh"

module mem_latency_timer (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic start,
    output logic done
);

    localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);

    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_BITS'(`MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last counting cycle, MEM_LATENCY cycles after start
    assign done = count == CNT_BITS'(1);

    a_no_restart: assert property (
        @(posedge clk) disable iff (reset || flush)
        start |-> count == '0
    ) else $error("mem_latency_timer: start while counting");

endmodule

// ==== hw/data_mem.sv ====
`timescale 1ns/100ps
`include "lsu_defines.svh"

module data_mem
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      en,
    input  logic      we,
    input  mem_addr_t addr,
    input  word_t     wdata,
    output word_t     rdata
);

    localparam int WORDS = 2 ** `MEM_ADDR_BITS;

    word_t mem [WORDS];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // write port
    always @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, held between accesses
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        issue_valid,
    input  ls_issue_t   issue,
    input  cdb_t        cdb [`CDB_PORTS],
    input  rob_tag_t    rob_head,
    output logic        full,
    output logic        result_valid,
    output lsu_result_t result
);

    logic      accept;
    logic      disp_valid;
    ls_entry_t disp;

    logic timer_start;
    logic timer_done;

    logic      mem_en;
    logic      mem_we;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;

    ls_buffer u_ls_buffer (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb         (cdb),
        .rob_head    (rob_head),
        .accept      (accept),
        .full        (full),
        .disp_valid  (disp_valid),
        .disp        (disp)
    );

    mem_ctrl_fsm u_mem_ctrl_fsm (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .disp_valid   (disp_valid),
        .disp         (disp),
        .timer_done   (timer_done),
        .mem_rdata    (mem_rdata),
        .accept       (accept),
        .timer_start  (timer_start),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .result_valid (result_valid),
        .result       (result)
    );

    mem_latency_timer u_mem_latency_timer (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .start (timer_start),
        .done  (timer_done)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// ==== tests/tb_lsu.sv ====
`timescale 1ns/100ps
`include "lsu_defines.svh"

module tb_lsu
    import lsu_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        flush;
    logic        issue_valid;
    ls_issue_t   issue;
    cdb_t        cdb [`CDB_PORTS];
    rob_tag_t    rob_head;
    logic        full;
    logic        result_valid;
    lsu_result_t result;

    lsu_result_t expected_q [$];
    string       records [$];
    logic        records_loaded = 1'b0;
    int          watchdog_ns;

    lsu_top dut (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .cdb          (cdb),
        .rob_head     (rob_head),
        .full         (full),
        .result_valid (result_valid),
        .result       (result)
    );

    always #50 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(lsu_result_t exp, lsu_result_t act);
        string exp_text;
        string act_text;
        if (act !== exp) begin
            exp_text = $sformatf("op=%0d tag=%h rd=%h data=%h",
                                 exp.op, exp.tag, exp.rd, exp.data);
            act_text = $sformatf("op=%0d tag=%h rd=%h data=%h",
                                 act.op, act.tag, act.rd, act.data);
            $display("ERROR at %0t: result expected %s, got %s", $time, exp_text, act_text);
            abort_run("result mismatch");
        end
    endtask

    task automatic check_full(logic exp, logic act);
        if (act !== exp) begin
            $display("ERROR at %0t: full expected %b, got %b", $time, exp, act);
            abort_run("full flag mismatch");
        end
    endtask

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic idle_gap();
        repeat ($urandom % 3) next_cycle();
    endtask

    function automatic lsu_op_t op_from_name(string name);
        return (name == "sw") ? op_sw : op_lw;
    endfunction

    task automatic apply_record(string line);
        string       kind;
        string       op_name;
        ls_issue_t   ins;
        lsu_result_t exp;
        rob_tag_t    tag;
        rob_tag_t    btag;
        rob_tag_t    dtag;
        reg_idx_t    rd;
        word_t       value;
        word_t       dval;
        word_t       imm;
        logic [$clog2(`CDB_PORTS)-1:0] port;
        logic        level;
        int          n;
        void'($sscanf(line, "%s", kind));
        if (kind == "issue") begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h", kind, op_name, tag, rd,
                        btag, value, dtag, dval, imm);
            if (n != 9) abort_run($sformatf("malformed issue record: %s", line));
            ins.op       = op_from_name(op_name);
            ins.tag      = tag;
            ins.rd       = rd;
            ins.base_tag = btag;
            ins.base_val = value;
            ins.data_tag = dtag;
            ins.data_val = dval;
            ins.imm      = imm;
            idle_gap();
            issue       = ins;
            issue_valid = 1'b1;
            next_cycle();
            issue_valid = 1'b0;
        end else if (kind == "cdb") begin
            void'($sscanf(line, "%s %h %h %h", kind, port, tag, value));
            idle_gap();
            cdb[port] = '{valid: 1'b1, tag: tag, value: value};
            next_cycle();
            cdb[port].valid = 1'b0;
        end else if (kind == "head") begin
            void'($sscanf(line, "%s %h", kind, tag));
            idle_gap();
            rob_head = tag;
        end else if (kind == "flush") begin
            idle_gap();
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
        end else if (kind == "wait") begin
            void'($sscanf(line, "%s %d", kind, n));
            repeat (n) next_cycle();
        end else if (kind == "full") begin
            void'($sscanf(line, "%s %b", kind, level));
            check_full(level, full);
        end else if (kind == "expect") begin
            void'($sscanf(line, "%s %s %h %h %h", kind, op_name, tag, rd, value));
            exp.op   = op_from_name(op_name);
            exp.tag  = tag;
            exp.rd   = rd;
            exp.data = value;
            expected_q.push_back(exp);
        end else begin
            abort_run($sformatf("unknown record kind in cases file: %s", kind));
        end
    endtask

    // results are stable in the middle of the cycle
    always @(negedge clk) begin
        if (!reset && result_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("result with tag %h appeared at %0t when none was expected",
                                    result.tag, $time));
            end else begin
                check_result(expected_q.pop_front(), result);
            end
        end
    end

    initial begin
        wait (records_loaded);
        #(watchdog_ns);
        abort_run("watchdog expired before all cases finished");
    end

    initial begin
        int    fd;
        string line;
        string kind;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'he84c_d6be));
        clk         = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        cdb         = '{default: '0};
        rob_head    = '0;

        fd = $fopen("tests/lsu_cases.txt", "r");
        if (fd == 0) abort_run("could not open tests/lsu_cases.txt");
        while ($fgets(line, fd) != 0) begin
            // skip blank and comment lines
            if ($sscanf(line, "%s", kind) == 1 && kind.substr(0, 0) != "#") begin
                records.push_back(line);
            end
        end
        $fclose(fd);
        watchdog_ns    = records.size() * (`MEM_LATENCY + 2) * 100 + 2000;
        records_loaded = 1'b1;

        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        for (int r = 0; r < records.size(); r++) begin
            apply_record(records[r]);
        end

        // drain, then give a stray result time to show up
        for (int c = 0; c < 60 && expected_q.size() != 0; c++) begin
            next_cycle();
        end
        repeat (`MEM_LATENCY + 2) next_cycle();

        if (expected_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected results never appeared", expected_q.size()));
        end
    end

endmodule

// ==== tests/lsu_cases.txt ====
# issue op tag rd base_tag base_val data_tag data_val imm | cdb port tag value | head tag
# flush | wait cycles | full level | expect op tag rd data ; numbers are hex, wait is decimal
# stores then loads to the same words, all operands ready
head 01
issue sw 01 00 00 00000100 00 cafe0001 00000010
expect sw 01 00 00000000
issue sw 02 00 00 00000200 00 0badf00d 00000006
expect sw 02 00 00000000
head 02
issue lw 03 05 00 00000100 00 00000000 00000013
expect lw 03 05 cafe0001
issue lw 04 06 00 00000200 00 00000000 00000006
expect lw 04 06 0badf00d
# loads wait for their base on either CDB port
issue lw 05 07 0a deadbeef 00 00000000 00000008
issue lw 06 08 0b deadbeef 00 00000000 00000001
wait 8
cdb 1 0b 00000205
wait 4
cdb 0 0a 00000108
expect lw 05 07 cafe0001
expect lw 06 08 0badf00d
# store that is not the ROB head holds back the load behind it
issue sw 09 00 00 00000300 0c 00000000 00000000
issue lw 0a 09 00 00000300 00 00000000 00000000
wait 6
cdb 1 0c 12345678
wait 6
head 09
expect sw 09 00 00000000
expect lw 0a 09 12345678
# eight waiting loads fill the buffer
wait 16
issue lw 10 10 18 00000000 00 00000000 00000000
issue lw 11 11 19 00000000 00 00000000 00000000
issue lw 12 12 1a 00000000 00 00000000 00000000
issue lw 13 13 1b 00000000 00 00000000 00000000
issue lw 14 14 1c 00000000 00 00000000 00000000
issue lw 15 15 1d 00000000 00 00000000 00000000
issue lw 16 16 1e 00000000 00 00000000 00000000
full 0
issue lw 17 17 1f 00000000 00 00000000 00000000
full 1
cdb 0 18 00000110
expect lw 10 10 cafe0001
wait 8
full 0
# flush aborts the access in flight and drops the waiting loads
cdb 1 19 00000000
flush
full 0
cdb 0 1a 00000000
wait 10
head 12
issue lw 11 03 00 000002fc 00 00000000 00000004
expect lw 11 03 12345678
issue sw 12 00 00 000003f0 00 a5a5a5a5 00000000
expect sw 12 00 00000000
issue lw 13 04 00 000003f0 00 00000000 00000000
expect lw 13 04 a5a5a5a5

// ==== tb.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/ls_buffer.sv
hw/mem_ctrl_fsm.sv
hw/mem_latency_timer.sv
hw/data_mem.sv
hw/lsu_top.sv
tests/tb_lsu.sv

// ==== Makefile ====
# Verilator simulation of the load/store unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_lsu -o tb_lsu
	./obj_dir/tb_lsu | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
